// ==== ahb_pkg.sv ====
// AHB protocol package with bus field widths, transfer types and the address phase struct
package ahb_pkg;

  //----------------------------------------
  // Bus field widths
  //----------------------------------------
  localparam int HADDR_W   = 32;                   // Byte address
  localparam int HDATA_W   = 32;                   // Write data bus
  localparam int HSIZE_W   = 3;                    // Transfer size field
  localparam int HBURST_W  = 3;                    // Burst type field
  localparam int HMASTER_W = 4;                    // Master ID field

  typedef logic [HADDR_W-1:0]   haddr_t;           // Address bus
  typedef logic [HDATA_W-1:0]   hdata_t;           // Write data bus
  typedef logic [HSIZE_W-1:0]   hsize_t;           // Log2 of bytes per beat
  typedef logic [HBURST_W-1:0]  hburst_t;          // Passed through only
  typedef logic [HMASTER_W-1:0] hmaster_t;         // Originating master

  //----------------------------------------
  // Transfer type
  //----------------------------------------
  // Bit 1 set means a real transfer is being started or continued
  typedef enum logic [1:0] {
    IDLE   = 2'b00,                                // No transfer
    BUSY   = 2'b01,                                // Burst pause
    NONSEQ = 2'b10,                                // First beat or single
    SEQ    = 2'b11                                 // Following beat
  } htrans_e;

  //----------------------------------------
  // Address phase bundle
  //----------------------------------------
  typedef struct packed {
    logic     hsel;                                // Slave select
    haddr_t   haddr;                               // Address
    htrans_e  htrans;                              // Transfer type
    logic     hwrite;                              // High for write
    hsize_t   hsize;                               // Transfer size
    hburst_t  hburst;                              // Burst type
    hmaster_t hmaster;                             // Master ID
    logic     hmastlock;                           // Locked sequence
  } ahb_addr_ctrl_s;

endpackage

// ==== mtx_pkg.sv ====
// Bus matrix package with port count, port codes, lock states and the input port bundle
package mtx_pkg;

  import ahb_pkg::*;

  //----------------------------------------
  // Port numbering
  //----------------------------------------
  localparam int NUM_PORTS = 3;                    // Input ports on this stage

  // Codes 1 to NUM_PORTS name a port
  typedef logic [1:0] port_id_t;

  localparam port_id_t PORT_NONE = 2'd0;           // Unused code naming no port

  //----------------------------------------
  // Input port bundle
  //----------------------------------------
  typedef struct packed {
    logic           held_tran;                     // Input stage holds a transfer
    ahb_addr_ctrl_s ac;                            // Held address phase
  } mtx_port_in_s;

  //----------------------------------------
  // Lock tracker states
  //----------------------------------------
  // HELD keeps the grant through cycles where the locked master
  // drops HSEL to talk to another slave
  typedef enum logic {
    LOCK_OPEN = 1'b0,                              // No locked sequence
    LOCK_HELD = 1'b1                               // Locked sequence in flight
  } lock_state_e;

endpackage

// ==== mtx_rr_arbiter.sv ====
// Round-robin arbiter for the shared slave with locked-sequence tracking
`timescale 1ns/10ps

module mtx_rr_arbiter
  import ahb_pkg::*;
  import mtx_pkg::*;
(
  input  logic           HCLK,                     // AHB clock
  input  logic           HRESETn,                  // Sync reset, active low
  input  mtx_port_in_s   i_ports [1:NUM_PORTS],    // Held requests per port
  input  ahb_addr_ctrl_s i_sel_ac,                 // Phase currently routed to slave
  input  logic           i_hreadymux,              // Accept strobe
  output port_id_t       o_grant,                  // Granted port code
  output logic           o_no_port                 // Nothing granted
);

  //----------------------------------------
  // Declarations
  //----------------------------------------
  logic [NUM_PORTS:1] req;                         // Per-port request
  port_id_t           last_port_q;                 // Last granted port
  lock_state_e        lock_state_q;                // Lock tracker state
  lock_state_e        lock_state_d;                // Next lock state
  ahb_addr_ctrl_s     last_ac;                     // Control of last granted port
  logic               locked_xfer;                 // Selected locked transfer
  logic               hold;                        // Keep grant on last port

  // Nearest requester after the last port or PORT_NONE
  function automatic port_id_t rr_pick(input logic [NUM_PORTS:1] reqs,
                                       input port_id_t last);
    port_id_t pick;
    int       cand;
    pick = PORT_NONE;
    // Scan from furthest to nearest so the nearest one wins
    for (int off = NUM_PORTS; off >= 1; off--)
    begin
      cand = ((int'(last) - 1 + off) % NUM_PORTS) + 1;
      if (reqs[cand])
        pick = port_id_t'(cand);
    end
    return pick;
  endfunction

  //----------------------------------------
  // Requests and lock hold
  //----------------------------------------
  always_comb
  begin
    last_ac = '0;                                  // Last port is never code 0
    for (int p = 1; p <= NUM_PORTS; p++)
    begin
      req[p] = i_ports[p].held_tran & i_ports[p].ac.hsel; // Held and aimed here
      if (last_port_q == port_id_t'(p))
        last_ac = i_ports[p].ac;                   // Control of holder
    end
  end

  // While held the granted port is the last port, so its own control is
  // the selected control; reading it here keeps the grant free of a loop
  // through the address mux
  assign hold = last_ac.hmastlock & (last_ac.hsel | (lock_state_q == LOCK_HELD));

  assign o_grant   = hold ? last_port_q : rr_pick(req, last_port_q);
  assign o_no_port = ~hold & ~(|req);              // Idle stage

  //----------------------------------------
  // Last granted port
  //----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      last_port_q <= port_id_t'(NUM_PORTS);        // Port 1 wins first
    else if (i_hreadymux && !o_no_port)
      last_port_q <= o_grant;                      // Advance on accepted phase
  end

  //----------------------------------------
  // Lock tracker FSM
  //----------------------------------------
  assign locked_xfer = i_sel_ac.hsel & i_sel_ac.hmastlock
                     & ((i_sel_ac.htrans == NONSEQ) | (i_sel_ac.htrans == SEQ));

  always_comb
  begin
    lock_state_d = lock_state_q;                   // Hold by default
    unique case (lock_state_q)
      LOCK_OPEN:
      begin
        if (locked_xfer)
          lock_state_d = LOCK_HELD;                // Locked beat accepted
      end
      LOCK_HELD:
      begin
        if (!i_sel_ac.hmastlock)
          lock_state_d = LOCK_OPEN;                // Master left the sequence
      end
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      lock_state_q <= LOCK_OPEN;
    else if (i_hreadymux)
      lock_state_q <= lock_state_d;                // Only on accepted edges
  end

endmodule

// ==== mtx_addr_mux.sv ====
// Address phase mux routing the granted port to the slave and decoding active flags
`timescale 1ns/10ps

module mtx_addr_mux
  import ahb_pkg::*;
  import mtx_pkg::*;
(
  input  mtx_port_in_s       i_ports [1:NUM_PORTS], // Held requests per port
  input  port_id_t           i_grant,               // Granted port code
  input  logic               i_no_port,             // Nothing granted
  output ahb_addr_ctrl_s     o_sel_ac,              // Phase routed to slave
  output logic [NUM_PORTS:1] o_active               // Bit n flags port n
);

  //----------------------------------------
  // Granted port select
  //----------------------------------------
  // Zero phase when idle keeps HSEL and HTRANS low at the slave
  always_comb
  begin
    o_sel_ac = '0;                                 // Idle phase
    o_active = '0;                                 // No port active
    if (!i_no_port)
    begin
      for (int p = 1; p <= NUM_PORTS; p++)
      begin
        if (i_grant == port_id_t'(p))
        begin
          o_sel_ac    = i_ports[p].ac;             // Route whole phase
          o_active[p] = 1'b1;                      // One-hot active
        end
      end
    end
  end

  // Held transfer flags stay with the arbiter; this block only steers
  // the address and control fields, HBURST included as a plain pass

endmodule

// ==== mtx_data_phase.sv ====
// Data phase block with port register, write data mux and HREADYMUX generation
`timescale 1ns/10ps

module mtx_data_phase
  import ahb_pkg::*;
  import mtx_pkg::*;
(
  input  logic     HCLK,                           // AHB clock
  input  logic     HRESETn,                        // Sync reset, active low
  input  hdata_t   i_wdata [1:NUM_PORTS],          // Write data per port
  input  port_id_t i_grant,                        // Address phase grant
  input  logic     i_hsel,                         // Slave selected this phase
  input  logic     i_hreadyout,                    // Slave ready
  output hdata_t   o_hwdata,                       // Write data to slave
  output logic     o_hreadymux                     // Bus accept strobe
);

  //----------------------------------------
  // Data phase registers
  //----------------------------------------
  port_id_t data_port_q;                           // Port in data phase
  logic     slave_sel_q;                           // Slave selected in data phase

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q <= PORT_NONE;
      slave_sel_q <= 1'b0;                         // Ready high out of reset
    end
    else if (o_hreadymux)
    begin
      data_port_q <= i_grant;                      // Address moves to data phase
      slave_sel_q <= i_hsel;
    end
  end

  //----------------------------------------
  // Write data mux
  //----------------------------------------
  always_comb
  begin
    o_hwdata = '0;                                 // Code 0 gives zero
    for (int p = 1; p <= NUM_PORTS; p++)
    begin
      if (data_port_q == port_id_t'(p))
        o_hwdata = i_wdata[p];
    end
  end

  //----------------------------------------
  // HREADYMUX
  //----------------------------------------
  // Only a selected slave may stall; otherwise the stage is always ready
  assign o_hreadymux = slave_sel_q ? i_hreadyout : 1'b1;

endmodule

// ==== mtx_output_stage.sv ====
// Shared slave output stage joining arbiter, address mux and data phase logic
`timescale 1ns/10ps

module mtx_output_stage
  import ahb_pkg::*;
  import mtx_pkg::*;
(
  input  logic               HCLK,                 // AHB clock
  input  logic               HRESETn,              // Sync reset, active low
  input  mtx_port_in_s       i_ports [1:NUM_PORTS], // Held requests per port
  input  hdata_t             i_wdata [1:NUM_PORTS], // Write data per port
  input  logic               i_hreadyout,          // Slave ready
  output logic [NUM_PORTS:1] o_active,             // Bit n flags port n
  output ahb_addr_ctrl_s     o_slave_ac,           // Address phase to slave
  output hdata_t             o_hwdata,             // Write data to slave
  output logic               o_hreadymux           // Bus accept strobe
);

  //----------------------------------------
  // Internal wires
  //----------------------------------------
  port_id_t grant;                                 // Arbiter decision
  logic     no_port;                               // Stage idle

  //----------------------------------------
  // Arbitration
  //----------------------------------------
  // Sees the routed phase for lock tracking
  mtx_rr_arbiter mtx_rr_arbiter_inst (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_ports     (i_ports),
    .i_sel_ac    (o_slave_ac),                     // Fed back from mux
    .i_hreadymux (o_hreadymux),
    .o_grant     (grant),
    .o_no_port   (no_port)
  );

  //----------------------------------------
  // Address phase
  //----------------------------------------
  mtx_addr_mux mtx_addr_mux_inst (
    .i_ports   (i_ports),
    .i_grant   (grant),
    .i_no_port (no_port),
    .o_sel_ac  (o_slave_ac),                       // Zero latency to slave
    .o_active  (o_active)
  );

  //----------------------------------------
  // Data phase
  //----------------------------------------
  // Write data trails the accepted address by one phase
  mtx_data_phase mtx_data_phase_inst (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_wdata     (i_wdata),
    .i_grant     (grant),
    .i_hsel      (o_slave_ac.hsel),                // Selection of routed phase
    .i_hreadyout (i_hreadyout),
    .o_hwdata    (o_hwdata),
    .o_hreadymux (o_hreadymux)                     // Also steers the arbiter
  );

endmodule

// ==== tb_vectors.svh ====
// Stimulus and expected value table for the shared slave output stage testbench
// Each row holds held, sel, lock and htrans per port (p3 p2 p1) and hreadyout
// followed by expected active, granted port, data phase port and hreadymux

localparam int NUM_ROWS = 25;                      // Rows in the table

vec_row_s vectors [NUM_ROWS];                      // Table filled at start of run

task automatic load_vectors();
  //----------------------------------------
  // Idle after reset, lone requesters
  //----------------------------------------
  vectors[0]  = '{3'b000, 3'b000, 3'b000, 6'b00_00_00, 1'b1, 3'b000, 2'd0, 2'd0, 1'b1};
  vectors[1]  = '{3'b010, 3'b010, 3'b000, 6'b00_10_00, 1'b1, 3'b010, 2'd2, 2'd0, 1'b1};
  vectors[2]  = '{3'b100, 3'b100, 3'b000, 6'b10_00_00, 1'b1, 3'b100, 2'd3, 2'd2, 1'b1};
  vectors[3]  = '{3'b000, 3'b000, 3'b000, 6'b00_00_00, 1'b1, 3'b000, 2'd0, 2'd3, 1'b1};
  // Slave not selected, so a low ready has no effect
  vectors[4]  = '{3'b000, 3'b000, 3'b000, 6'b00_00_00, 1'b0, 3'b000, 2'd0, 2'd0, 1'b1};

  //----------------------------------------
  // Rotation with all ports requesting
  //----------------------------------------
  vectors[5]  = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b001, 2'd1, 2'd0, 1'b1};
  vectors[6]  = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b010, 2'd2, 2'd1, 1'b1};
  vectors[7]  = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b100, 2'd3, 2'd2, 1'b1};
  vectors[8]  = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b001, 2'd1, 2'd3, 1'b1};

  //----------------------------------------
  // Slave stall, grant and data hold
  //----------------------------------------
  vectors[9]  = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b0, 3'b010, 2'd2, 2'd1, 1'b0};
  vectors[10] = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b0, 3'b010, 2'd2, 2'd1, 1'b0};
  vectors[11] = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b010, 2'd2, 2'd1, 1'b1};
  vectors[12] = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b100, 2'd3, 2'd2, 1'b1};

  //----------------------------------------
  // Locked sequence from port 3
  //----------------------------------------
  vectors[13] = '{3'b111, 3'b111, 3'b100, 6'b10_10_10, 1'b1, 3'b100, 2'd3, 2'd3, 1'b1};
  vectors[14] = '{3'b111, 3'b111, 3'b100, 6'b11_10_10, 1'b1, 3'b100, 2'd3, 2'd3, 1'b1};
  // Port 3 drops HSEL but keeps the lock
  vectors[15] = '{3'b111, 3'b011, 3'b100, 6'b00_10_10, 1'b1, 3'b100, 2'd3, 2'd3, 1'b1};
  vectors[16] = '{3'b111, 3'b111, 3'b100, 6'b11_10_10, 1'b0, 3'b100, 2'd3, 2'd3, 1'b1};
  // Lock falls and round robin resumes
  vectors[17] = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b001, 2'd1, 2'd3, 1'b1};
  vectors[18] = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b1, 3'b010, 2'd2, 2'd1, 1'b1};

  //----------------------------------------
  // Stall then drain to idle
  //----------------------------------------
  vectors[19] = '{3'b111, 3'b111, 3'b000, 6'b10_10_10, 1'b0, 3'b100, 2'd3, 2'd2, 1'b0};
  vectors[20] = '{3'b001, 3'b001, 3'b000, 6'b00_00_10, 1'b1, 3'b001, 2'd1, 2'd2, 1'b1};
  vectors[21] = '{3'b000, 3'b000, 3'b000, 6'b00_00_00, 1'b0, 3'b000, 2'd0, 2'd1, 1'b0};
  vectors[22] = '{3'b000, 3'b000, 3'b000, 6'b00_00_00, 1'b1, 3'b000, 2'd0, 2'd1, 1'b1};
  vectors[23] = '{3'b000, 3'b000, 3'b000, 6'b00_00_00, 1'b0, 3'b000, 2'd0, 2'd0, 1'b1};
  // HSEL without a held transfer is no request
  vectors[24] = '{3'b000, 3'b010, 3'b000, 6'b00_10_00, 1'b1, 3'b000, 2'd0, 2'd0, 1'b1};
endtask

// ==== tb_mtx_output_stage.sv ====
// Testbench for the shared slave output stage, table driven with random address and data
`timescale 1ns/10ps

module tb_mtx_output_stage
  import ahb_pkg::*;
  import mtx_pkg::*;
();

  //----------------------------------------
  // Constants and types
  //----------------------------------------
  localparam int CLK_HALF     = 20;                // 40 ns period
  localparam int RESET_CYCLES = 16;                // Reset length
  localparam int CHECK_DELAY  = 10;                // Sample point after drive

  typedef struct packed {
    logic [NUM_PORTS:1]      held;                 // held_tran per port
    logic [NUM_PORTS:1]      sel;                  // hsel per port
    logic [NUM_PORTS:1]      lock;                 // hmastlock per port
    logic [NUM_PORTS:1][1:0] trans;                // htrans per port
    logic                    hready;               // Slave ready
    logic [NUM_PORTS:1]      exp_active;           // Expected active flags
    port_id_t                exp_port;             // Expected granted port
    port_id_t                exp_dport;            // Expected data phase port
    logic                    exp_hrm;              // Expected hreadymux
  } vec_row_s;

  `include "tb_vectors.svh"

  localparam int TIMEOUT_CYCLES = NUM_ROWS + RESET_CYCLES + 20;

  //----------------------------------------
  // DUT signals
  //----------------------------------------
  logic               HCLK;
  logic               HRESETn;
  mtx_port_in_s       port_in [1:NUM_PORTS];       // Per-port request bundle
  hdata_t             wdata   [1:NUM_PORTS];       // Per-port write data
  logic               hreadyout;
  logic [NUM_PORTS:1] o_active;
  ahb_addr_ctrl_s     o_slave_ac;
  hdata_t             o_hwdata;
  logic               o_hreadymux;

  int row_idx     = 0;                             // Row under test
  int errors      = 0;                             // Mismatch count
  int cycle_count = 0;                             // Cycles since start

  mtx_output_stage mtx_output_stage_inst (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .i_ports     (port_in),
    .i_wdata     (wdata),
    .i_hreadyout (hreadyout),
    .o_active    (o_active),
    .o_slave_ac  (o_slave_ac),
    .o_hwdata    (o_hwdata),
    .o_hreadymux (o_hreadymux)
  );

  //----------------------------------------
  // Clock and timeout
  //----------------------------------------
  initial
  begin
    HCLK = 1'b0;
    forever #CLK_HALF HCLK = ~HCLK;
  end

  always @(posedge HCLK)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $fatal(1, "run aborted by timeout");
    end
  end

  //----------------------------------------
  // Helpers
  //----------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Error: %s row %0d got 0x%h expected 0x%h", name, row_idx, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Address phase the slave should see for a given port code
  function automatic ahb_addr_ctrl_s port_ac(input port_id_t port);
    ahb_addr_ctrl_s ac;
    ac = '0;                                       // Zero phase for code 0
    for (int p = 1; p <= NUM_PORTS; p++)
    begin
      if (port == port_id_t'(p))
        ac = port_in[p].ac;
    end
    return ac;
  endfunction

  function automatic hdata_t port_wdata(input port_id_t port);
    hdata_t d;
    d = '0;                                        // Code 0 reads zero
    for (int p = 1; p <= NUM_PORTS; p++)
    begin
      if (port == port_id_t'(p))
        d = wdata[p];
    end
    return d;
  endfunction

  task automatic drive_row(input int k);
    vec_row_s r;
    r = vectors[k];
    for (int p = 1; p <= NUM_PORTS; p++)
    begin
      port_in[p].held_tran    = r.held[p];
      port_in[p].ac.hsel      = r.sel[p];
      port_in[p].ac.haddr     = $urandom;          // Random fields
      port_in[p].ac.htrans    = htrans_e'(r.trans[p]);
      port_in[p].ac.hwrite    = 1'($urandom);
      port_in[p].ac.hsize     = hsize_t'($urandom);
      port_in[p].ac.hburst    = hburst_t'($urandom);
      port_in[p].ac.hmaster   = hmaster_t'($urandom);
      port_in[p].ac.hmastlock = r.lock[p];
      wdata[p]                = $urandom;
    end
    hreadyout = r.hready;
  endtask

  task automatic check_row(input int k);
    vec_row_s r;
    r = vectors[k];
    check_value("o_active", 64'(o_active), 64'(r.exp_active));
    check_value("o_slave_ac", 64'(o_slave_ac), 64'(port_ac(r.exp_port)));
    check_value("o_hwdata", 64'(o_hwdata), 64'(port_wdata(r.exp_dport)));
    check_value("o_hreadymux", 64'(o_hreadymux), 64'(r.exp_hrm));
  endtask

  //----------------------------------------
  // Main sequence
  //----------------------------------------
  initial
  begin
    void'($urandom(32'hb4d3));                     // Fixed seed
    HRESETn   = 1'b0;
    hreadyout = 1'b1;
    for (int p = 1; p <= NUM_PORTS; p++)
    begin
      port_in[p] = '0;
      wdata[p]   = '0;
    end
    load_vectors();
    repeat (RESET_CYCLES) @(negedge HCLK);
    HRESETn = 1'b1;                                // Release on falling edge
    for (int k = 0; k < NUM_ROWS; k++)
    begin
      @(negedge HCLK);
      row_idx = k;
      drive_row(k);
      #CHECK_DELAY;                                // Well before next rise
      check_row(k);
    end
    if (errors == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
    begin
      $display("CHECKS FAILED");
      $fatal(1, "mismatches found");
    end
  end

endmodule

// ==== vlog.f ====
+incdir+.
ahb_pkg.sv
mtx_pkg.sv
mtx_rr_arbiter.sv
mtx_addr_mux.sv
mtx_data_phase.sv
mtx_output_stage.sv
tb_mtx_output_stage.sv

// ==== Makefile ====
# Verilator build and run for the shared slave output stage

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mtx_output_stage
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
